// File: rtl/notch_cfg.svh
// notch filter configuration: bus widths, address step, queue depth and reset coefficients
`ifndef NOTCH_CFG_SVH
`define NOTCH_CFG_SVH

`define NOTCH_ADDR_W 24 // memory byte address
`define NOTCH_DATA_W 32 // bus word and sample
`define NOTCH_COEF_W 16 // Q2.14 coefficient
`define NOTCH_FRAC 14 // coefficient fraction bits
`define NOTCH_ADDR_STEP 4 // bytes per sample
`define NOTCH_FIFO_DEPTH 8 // fetch and store queues

// default notch, scaled by 2^14
`define NOTCH_A1_DEF (-16'sd31035)
`define NOTCH_A2_DEF (16'sd14969)
`define NOTCH_B0_DEF (16'sd8275)
`define NOTCH_B1_DEF (-16'sd16383)
`define NOTCH_B2_DEF (16'sd8275)

`endif

// File: rtl/notchPkg.sv
// notch filter shared types: samples, coefficients, run config, queue items, bus structs
`default_nettype none
`include "notch_cfg.svh"

package notchPkg;

	typedef logic signed [`NOTCH_DATA_W-1:0] sample_t; // one memory word
	typedef logic signed [`NOTCH_COEF_W-1:0] coef_t; // Q2.14
	typedef logic [`NOTCH_ADDR_W-1:0] addr_t; // byte address
	typedef logic [`NOTCH_DATA_W-1:0] regWord_t; // host register word

	typedef struct packed {
		coef_t a1; // feedback taps
		coef_t a2;
		coef_t b0; // feedforward taps
		coef_t b1;
		coef_t b2;
	} coefSet_t;

	typedef struct packed {
		addr_t base; // first sample
		logic [`NOTCH_ADDR_W-1:0] count; // samples in block
		logic filterEnable; // 0 writes x back
		coefSet_t coefs;
	} runCfg_t;

	typedef struct packed {
		sample_t data;
		logic last; // final sample of run
	} fetchItem_t;

	typedef struct packed {
		sample_t data; // y or x, per mode
		logic last;
	} resultItem_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		addr_t adr;
		logic [`NOTCH_DATA_W-1:0] dat;
	} wbReq_t;

	typedef struct packed {
		logic ack;
		logic [`NOTCH_DATA_W-1:0] dat;
	} wbRsp_t;

endpackage

`default_nettype wire

// File: rtl/syncFifo.sv
// synchronous register-array FIFO, payload type set per instance
`default_nettype none

module syncFifo #(
	parameter type itemT = logic,
	parameter int DEPTH = 8
) (
	input wire clk,
	input wire rstN,
	input wire pushValid,
	input wire itemT pushItem,
	output logic pushReady,
	output logic popValid,
	output itemT popItem,
	input wire popReady,
	output logic [$clog2(DEPTH+1)-1:0] freeSlots
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // pointer width
	localparam int CW = $clog2(DEPTH+1); // fill width

	itemT mem [DEPTH]; // storage, no reset
	logic [PW-1:0] wrPtr, rdPtr;
	logic [CW-1:0] fill; // entries held

	wire doPush = pushValid && pushReady; // never writes a full queue
	wire doPop = popValid && popReady; // never reads an empty one

	assign pushReady = (fill != CW'(DEPTH));
	assign popValid = (fill != '0);
	assign popItem = mem[rdPtr]; // head, read combinationally
	assign freeSlots = CW'(DEPTH) - fill;

	always_ff @(posedge clk) begin
		if (doPush) mem[wrPtr] <= pushItem;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
		end else begin
			if (doPush) wrPtr <= (wrPtr == PW'(DEPTH-1)) ? '0 : wrPtr + 1'b1; // wrap
			if (doPop) rdPtr <= (rdPtr == PW'(DEPTH-1)) ? '0 : rdPtr + 1'b1;
			fill <= fill + CW'(doPush) - CW'(doPop); // both at once keeps level
		end
	end

endmodule

`default_nettype wire

// File: rtl/notchRegs.sv
// notch host registers: Wishbone slave, coefficients, run control, done flag and irq
`default_nettype none
`include "notch_cfg.svh"

module notchRegs import notchPkg::*; (
	input wire clk,
	input wire rstN,
	input wire wbReq_t hostReq,
	output wbRsp_t hostRsp,
	output logic runStart,
	output runCfg_t runCfg,
	input wire storeDone,
	input wire irqUnusedGuard_n,
	output logic irq
);

	coefSet_t coefs; // host-side taps
	addr_t base; // block start, bytes
	logic [`NOTCH_ADDR_W-1:0] count; // samples per run
	logic busy; // run in progress
	logic done; // sticky until status read
	logic [3:0] idx; // word index
	regWord_t rdData;

	assign idx = hostReq.adr[5:2];

	wire hostHit = hostReq.cyc && hostReq.stb && !hostRsp.ack; // first strobe cycle
	wire hostWr = hostHit && hostReq.we;
	wire startOk = hostWr && idx == 4'd0 && hostReq.dat[0] && !busy && count != '0;

	assign irq = done; // irq follows done

	always_comb begin
		case (idx)
			4'd0: rdData = {30'b0, runCfg.filterEnable, 1'b0}; // mode of last run
			4'd1: rdData = 32'(coefs.a1); // sign-extended
			4'd2: rdData = 32'(coefs.a2);
			4'd3: rdData = 32'(coefs.b0);
			4'd4: rdData = 32'(coefs.b1);
			4'd5: rdData = 32'(coefs.b2);
			4'd6: rdData = 32'(base);
			4'd7: rdData = 32'(count);
			4'd8: rdData = {30'b0, done, busy}; // status
			default: rdData = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hostRsp <= '0;
			coefs <= '{a1: `NOTCH_A1_DEF, a2: `NOTCH_A2_DEF, b0: `NOTCH_B0_DEF,
				b1: `NOTCH_B1_DEF, b2: `NOTCH_B2_DEF};
			base <= '0;
			count <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			runStart <= 1'b0;
			runCfg <= '0;
		end else begin
			hostRsp.ack <= hostHit; // one cycle after strobe, no wait states
			if (hostHit) hostRsp.dat <= rdData;
			runStart <= startOk; // one-cycle pulse
			if (hostWr) begin
				case (idx)
					4'd1: coefs.a1 <= coef_t'(hostReq.dat[15:0]);
					4'd2: coefs.a2 <= coef_t'(hostReq.dat[15:0]);
					4'd3: coefs.b0 <= coef_t'(hostReq.dat[15:0]);
					4'd4: coefs.b1 <= coef_t'(hostReq.dat[15:0]);
					4'd5: coefs.b2 <= coef_t'(hostReq.dat[15:0]);
					4'd6: base <= hostReq.dat[`NOTCH_ADDR_W-1:0];
					4'd7: count <= hostReq.dat[`NOTCH_ADDR_W-1:0];
					default: ;
				endcase
			end
			if (startOk) begin // snapshot held for the whole run
				busy <= 1'b1;
				runCfg <= '{base: base, count: count, filterEnable: hostReq.dat[1],
					coefs: coefs};
			end
			if (storeDone) begin
				busy <= 1'b0;
				done <= 1'b1;
			end else if (hostHit && !hostReq.we && idx == 4'd8) begin
				done <= 1'b0; // status read services irq
			end
		end
	end

	// last write acked only inside a run
	assert property (@(posedge clk) disable iff (!rstN) storeDone |-> busy);

endmodule

`default_nettype wire

// File: rtl/sampleFetch.sv
// sample fetcher: reads the block from memory and queues samples for the core
`default_nettype none
`include "notch_cfg.svh"

module sampleFetch import notchPkg::*; (
	input wire clk,
	input wire rstN,
	input wire runStart,
	input wire runCfg_t runCfg,
	output wbReq_t memReq,
	input wire wbRsp_t memRsp,
	output logic sampleValid,
	output fetchItem_t sampleItem,
	input wire sampleReady
);

	localparam int FW = $clog2(`NOTCH_FIFO_DEPTH+1);

	logic rdStb; // read in flight
	addr_t rdAddr;
	logic [`NOTCH_ADDR_W-1:0] toIssue; // reads not yet started
	logic rdLast; // in-flight read is final sample
	logic [FW-1:0] freeSlots;
	fetchItem_t inItem;

	assign memReq = '{cyc: rdStb, stb: rdStb, we: 1'b0, adr: rdAddr, dat: '0};
	assign inItem = '{data: sample_t'(memRsp.dat), last: rdLast};

	// one read at a time, so a free slot is never already claimed when issuing
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rdStb <= 1'b0;
			rdAddr <= '0;
			toIssue <= '0;
			rdLast <= 1'b0;
		end else if (runStart) begin
			rdStb <= 1'b0;
			rdAddr <= runCfg.base;
			toIssue <= runCfg.count;
		end else if (rdStb) begin
			if (memRsp.ack) begin // data lands in queue this edge
				rdStb <= 1'b0;
				rdAddr <= rdAddr + addr_t'(`NOTCH_ADDR_STEP);
			end
		end else if (toIssue != '0 && freeSlots != '0) begin
			rdStb <= 1'b1;
			rdLast <= (toIssue == `NOTCH_ADDR_W'(1));
			toIssue <= toIssue - 1'b1;
		end
	end

	syncFifo #(
		.itemT(fetchItem_t),
		.DEPTH(`NOTCH_FIFO_DEPTH)
	) u_fetchFifo (
		.clk(clk),
		.rstN(rstN),
		.pushValid(rdStb && memRsp.ack), // slot reserved at issue
		.pushItem(inItem),
		.pushReady(),
		.popValid(sampleValid),
		.popItem(sampleItem),
		.popReady(sampleReady),
		.freeSlots(freeSlots)
	);

endmodule

`default_nettype wire

// File: rtl/biquadCore.sv
// biquad core: history, registered products, then sum, Q2.14 shift and history update
`default_nettype none
`include "notch_cfg.svh"

module biquadCore import notchPkg::*; (
	input wire clk,
	input wire rstN,
	input wire runStart,
	input wire runCfg_t runCfg,
	input wire sampleValid,
	input wire fetchItem_t sampleItem,
	output logic sampleReady,
	output logic resultValid,
	output resultItem_t resultItem,
	input wire resultReady
);

	localparam int PW = `NOTCH_DATA_W + `NOTCH_COEF_W; // product width
	localparam int AW = 2 * `NOTCH_DATA_W; // accumulator width

	sample_t x1, x2, y1, y2; // x(n-1), x(n-2), y(n-1), y(n-2)
	sample_t x0; // sample in multiply stage
	logic x0Last;
	logic mulValid; // products held
	logic signed [PW-1:0] pB0, pB1, pB2, pA1, pA2;
	logic signed [AW-1:0] acc;
	sample_t yNext;

	wire take = sampleValid && sampleReady;

	// next sample only after the previous result has gone
	assign sampleReady = !mulValid && (!resultValid || resultReady);

	always_comb begin
		acc = pB0 + pB1 + pB2 - pA1 - pA2; // sign-extended to 64
		yNext = sample_t'(acc >>> `NOTCH_FRAC); // low 32 after shift
	end

	// multiply stage
	always_ff @(posedge clk) begin
		if (take) begin
			x0 <= sampleItem.data;
			x0Last <= sampleItem.last;
			pB0 <= sampleItem.data * runCfg.coefs.b0;
			pB1 <= x1 * runCfg.coefs.b1;
			pB2 <= x2 * runCfg.coefs.b2;
			pA1 <= y1 * runCfg.coefs.a1;
			pA2 <= y2 * runCfg.coefs.a2;
		end
	end

	// sum-and-shift stage, result register
	always_ff @(posedge clk) begin
		if (mulValid) begin
			resultItem.data <= runCfg.filterEnable ? yNext : x0; // bypass writes x back
			resultItem.last <= x0Last;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mulValid <= 1'b0;
			resultValid <= 1'b0;
			x1 <= '0;
			x2 <= '0;
			y1 <= '0;
			y2 <= '0;
		end else begin
			mulValid <= take;
			if (mulValid) resultValid <= 1'b1;
			else if (resultReady) resultValid <= 1'b0; // handed to store queue
			if (runStart) begin // fresh history per run
				x1 <= '0;
				x2 <= '0;
				y1 <= '0;
				y2 <= '0;
			end else if (mulValid) begin // history advances even in bypass
				x1 <= x0;
				x2 <= x1;
				y1 <= yNext;
				y2 <= y1;
			end
		end
	end

	// back-pressured result must not move until the store takes it
	assert property (@(posedge clk) disable iff (!rstN)
		resultValid && !resultReady |=> resultValid && $stable(resultItem));

endmodule

`default_nettype wire

// File: rtl/resultStore.sv
// result store: queues core outputs and writes them back to memory in order
`default_nettype none
`include "notch_cfg.svh"

module resultStore import notchPkg::*; (
	input wire clk,
	input wire rstN,
	input wire runStart,
	input wire runCfg_t runCfg,
	input wire resultValid,
	input wire resultItem_t resultItem,
	output logic resultReady,
	output wbReq_t memReq,
	input wire wbRsp_t memRsp,
	output logic storeDone
);

	logic wrStb; // write in flight
	addr_t wrAddr;
	sample_t wrData;
	logic wrLast; // in-flight write ends the run
	logic qValid;
	resultItem_t qItem;

	wire load = qValid && !wrStb; // pop head into write regs

	assign memReq = '{cyc: wrStb, stb: wrStb, we: 1'b1, adr: wrAddr, dat: wrData};
	assign storeDone = wrStb && memRsp.ack && wrLast; // same cycle as final ack

	syncFifo #(
		.itemT(resultItem_t),
		.DEPTH(`NOTCH_FIFO_DEPTH)
	) u_storeFifo (
		.clk(clk),
		.rstN(rstN),
		.pushValid(resultValid),
		.pushItem(resultItem),
		.pushReady(resultReady), // full queue stalls core
		.popValid(qValid),
		.popItem(qItem),
		.popReady(!wrStb),
		.freeSlots()
	);

	always_ff @(posedge clk) begin
		if (load) begin
			wrData <= qItem.data;
			wrLast <= qItem.last;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrStb <= 1'b0;
			wrAddr <= '0;
		end else if (runStart) begin
			wrStb <= 1'b0;
			wrAddr <= runCfg.base; // results overwrite inputs in place
		end else if (wrStb) begin
			if (memRsp.ack) begin
				wrStb <= 1'b0;
				wrAddr <= wrAddr + addr_t'(`NOTCH_ADDR_STEP);
			end
		end else if (load) begin
			wrStb <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/memArbiter.sv
// memory arbiter: shares one Wishbone classic master port between fetcher and store
`default_nettype none

module memArbiter import notchPkg::*; (
	input wire clk,
	input wire rstN,
	input wire wbReq_t fetchReq,
	output wbRsp_t fetchRsp,
	input wire wbReq_t storeReq,
	output wbRsp_t storeRsp,
	output wbReq_t memReq,
	input wire wbRsp_t memRsp
);

	typedef enum logic {GRANT_FETCH, GRANT_STORE} grant_t;

	grant_t owner; // last granted master
	logic locked; // cycle open, grant frozen
	grant_t grant;

	always_comb begin
		if (locked) grant = owner;
		else if (fetchReq.stb) grant = GRANT_FETCH; // reads first
		else if (storeReq.stb) grant = GRANT_STORE;
		else grant = owner;
	end

	assign memReq = (grant == GRANT_STORE) ? storeReq : fetchReq;
	assign fetchRsp = '{ack: memRsp.ack && grant == GRANT_FETCH, dat: memRsp.dat};
	assign storeRsp = '{ack: memRsp.ack && grant == GRANT_STORE, dat: memRsp.dat};

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			owner <= GRANT_FETCH;
			locked <= 1'b0;
		end else begin
			owner <= grant;
			locked <= memReq.stb && !memRsp.ack; // hold until ack ends the access
		end
	end

	// an open classic cycle keeps its master until ack
	assert property (@(posedge clk) disable iff (!rstN)
		memReq.stb && !memRsp.ack |=> memReq.stb && $stable(memReq.we) && $stable(memReq.adr));

endmodule

`default_nettype wire

// File: rtl/notchTop.sv
// notch filter top: host registers, fetch, biquad core, store and memory arbiter
`default_nettype none

module notchTop import notchPkg::*; (
	input wire clk,
	input wire rstN,
	input wire wbReq_t hostReq,
	output wbRsp_t hostRsp,
	output wbReq_t memReq,
	input wire wbRsp_t memRsp,
	output logic irq
);

	logic runStart, storeDone;
	runCfg_t runCfg;
	wbReq_t fetchReq, storeReq;
	wbRsp_t fetchRsp, storeRsp;
	logic sampleValid, sampleReady, resultValid, resultReady;
	fetchItem_t sampleItem;
	resultItem_t resultItem;

	notchRegs u_notchRegs (.clk, .rstN, .hostReq, .hostRsp, .runStart, .runCfg, .storeDone,
		.irqUnusedGuard_n(1'b1), .irq);

	sampleFetch u_sampleFetch (.clk, .rstN, .runStart, .runCfg, .memReq(fetchReq),
		.memRsp(fetchRsp), .sampleValid, .sampleItem, .sampleReady);

	biquadCore u_biquadCore (.clk, .rstN, .runStart, .runCfg, .sampleValid, .sampleItem,
		.sampleReady, .resultValid, .resultItem, .resultReady);

	resultStore u_resultStore (.clk, .rstN, .runStart, .runCfg, .resultValid, .resultItem,
		.resultReady, .memReq(storeReq), .memRsp(storeRsp), .storeDone);

	memArbiter u_memArbiter (.clk, .rstN, .fetchReq, .fetchRsp, .storeReq, .storeRsp,
		.memReq, .memRsp);

endmodule

`default_nettype wire

// File: verif/notchTb.sv
// notch filter testbench: clock, Wishbone memory model, host register tasks and vector checks
`default_nettype none

module notchTb import notchPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int VEC_WORDS = 38; // two runs in the vector file
	localparam int MEM_WORDS = 256; // model covers byte addresses 0..1023
	localparam int ACK_TIMEOUT = 20;
	localparam int RUN_TIMEOUT = 4000;
	localparam int IRQ_CLEAR_TIMEOUT = 10;
	localparam int IDLE_WINDOW = 40; // watch for a stray second done
	// reset notch taps a1 a2 b0 b1 b2, sign-extended as read back
	localparam regWord_t DEF_COEF [5] = '{32'hFFFF86C5, 32'h00003A79, 32'h00002053,
		32'hFFFFC001, 32'h00002053};

	logic clk;
	logic rstN;
	wbReq_t hostReq;
	wbRsp_t hostRsp;
	wbReq_t memReq;
	wbRsp_t memRsp;
	logic irq;

	logic [31:0] vec [VEC_WORDS]; // packed runs, see vector file
	logic [31:0] mem [MEM_WORDS]; // word-addressed memory model
	logic [31:0] lfsrState = 32'hf5df;
	int irqRises = 0; // irq rising edges seen so far
	logic irqPrev = 1'b0;

	notchTop u_notchTop (.clk, .rstN, .hostReq, .hostRsp, .memReq, .memRsp, .irq);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "testbench stopped on first error");
	endtask

	task automatic checkSample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp) failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkReg(input string name, input regWord_t got, input regWord_t exp);
		if (got !== exp) failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1); // right-shift Galois form
	endfunction

	task automatic drawBits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsrState[0]); // one step per bit taken
			lfsrState = galoisStep(lfsrState);
		end
	endtask

	function automatic logic [31:0] fillWord(input int idx);
		return 32'hA5000000 | 32'(idx * 4); // tagged with full byte address
	endfunction

	// memory slave, 0..3 random wait states, one-cycle ack
	initial begin
		int waitLeft;
		int idx;
		waitLeft = -1;
		memRsp = '0;
		forever begin
			@(posedge clk);
			#1;
			if (memRsp.ack) begin
				memRsp.ack = 1'b0; // master drops stb at this edge
			end else if (memReq.cyc === 1'b1 && memReq.stb === 1'b1) begin
				if (waitLeft < 0) drawBits(2, waitLeft);
				if (waitLeft > 0) begin
					waitLeft--;
				end else if (memReq.adr[1:0] != 2'b00 || memReq.adr >= addr_t'(MEM_WORDS * 4)) begin
					failRun($sformatf("memory access to bad address %h", memReq.adr));
				end else begin
					idx = int'(memReq.adr[9:2]);
					if (memReq.we) mem[idx] = memReq.dat;
					else memRsp.dat = mem[idx];
					memRsp.ack = 1'b1;
					waitLeft = -1; // fresh draw for next access
				end
			end
		end
	end

	always @(negedge clk) begin
		if (irq === 1'b1 && irqPrev !== 1'b1) irqRises++;
		irqPrev <= irq;
	end

	task automatic hostAccess(input logic we, input int regIdx, input regWord_t wdata,
		output regWord_t rdata);
		int waited;
		waited = 0;
		rdata = '0;
		hostReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr_t'(regIdx * 4), dat: wdata};
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (hostRsp.ack !== 1'b1 && waited < ACK_TIMEOUT);
		if (hostRsp.ack !== 1'b1) begin
			failRun($sformatf("no ack from register %0d", regIdx));
		end else begin
			rdata = hostRsp.dat;
			hostReq = '0;
			@(posedge clk); // idle cycle between accesses
			#1;
		end
	endtask

	task automatic hostWrite(input int regIdx, input regWord_t wdata);
		regWord_t unused;
		hostAccess(1'b1, regIdx, wdata, unused);
	endtask

	task automatic hostRead(input int regIdx, output regWord_t rdata);
		hostAccess(1'b0, regIdx, '0, rdata);
	endtask

	task automatic waitIrq(input logic level, input int limit, input string what);
		int waited;
		waited = 0;
		while (irq !== level && waited < limit) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (irq !== level) failRun($sformatf("timeout waiting for irq %0b %s", level, what));
	endtask

	// one vector run: taps, block setup, start, second start while busy, checks
	task automatic runBlock(input int at, output int next);
		regWord_t r;
		logic mode;
		int count;
		int baseIdx;
		int risesBefore;
		mode = vec[at + 5][0];
		count = int'(vec[at + 6]);
		baseIdx = int'(vec[at + 7]) / 4;
		for (int i = 0; i < 5; i++) begin
			hostWrite(i + 1, regWord_t'(vec[at + i][15:0]));
			hostRead(i + 1, r);
			checkReg($sformatf("coef reg %0d", i + 1), r, {{16{vec[at + i][15]}}, vec[at + i][15:0]});
		end
		for (int i = 0; i < count; i++) mem[baseIdx + i] = vec[at + 8 + i];
		hostWrite(6, vec[at + 7]);
		hostWrite(7, regWord_t'(count));
		risesBefore = irqRises;
		hostWrite(0, regWord_t'({mode, 1'b1})); // start with mode
		hostRead(8, r);
		checkReg("status while running", r, 32'h1);
		hostWrite(0, regWord_t'({mode, 1'b1})); // must be ignored, still busy
		waitIrq(1'b1, RUN_TIMEOUT, "for end of run");
		hostRead(8, r);
		checkReg("status at done", r, 32'h2);
		waitIrq(1'b0, IRQ_CLEAR_TIMEOUT, "after status read");
		hostRead(8, r);
		checkReg("status after clear", r, 32'h0);
		for (int i = 0; i < count; i++) begin
			checkSample($sformatf("mem[%0d]", baseIdx + i), mem[baseIdx + i],
				vec[at + 8 + count + i]);
		end
		checkSample("mem below block", mem[baseIdx - 1], fillWord(baseIdx - 1));
		checkSample("mem above block", mem[baseIdx + count], fillWord(baseIdx + count));
		repeat (IDLE_WINDOW) @(posedge clk);
		#1;
		checkReg("irq rises per run", regWord_t'(irqRises - risesBefore), 32'h1);
		next = at + 8 + 2 * count;
	endtask

	initial begin
		regWord_t r;
		int at;
		hostReq = '0;
		rstN = 1'b0;
		$readmemh("verif/notch_vectors.txt", vec);
		for (int i = 0; i < MEM_WORDS; i++) mem[i] = fillWord(i);
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		if (vec[VEC_WORDS - 1] === 'x) failRun("vector file missing or short");
		checkReg("irq after reset", regWord_t'(irq), 32'h0);
		checkReg("memReq.cyc after reset", regWord_t'(memReq.cyc), 32'h0);
		for (int i = 0; i < 5; i++) begin
			hostRead(i + 1, r);
			checkReg($sformatf("default coef reg %0d", i + 1), r, DEF_COEF[i]);
		end
		hostRead(8, r);
		checkReg("status after reset", r, 32'h0);
		at = 0;
		runBlock(at, at); // filtered
		runBlock(at, at); // bypass
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/notch_vectors.txt
// notch filter runs, one block per run, 32-bit hex words
// a1 a2 b0 b1 b2 (Q2.14 in low half) / filterEnable count base / inputs / expected outputs
// run 1: filtered, y = (b0 x + b1 x1 + b2 x2 - a1 y1 - a2 y2) >>> 14
00002000 00000800 00004000 0000E000 00001000
00000001 00000006 00000040
000003E8 FFFFF830 00000BB8 000001F4 FFFFFFF9 00000028
000003E8 FFFFF448 000015F9 FFFFF09E 000006DE FFFFFF25
// run 2: bypass, inputs written back unchanged
0000C000 00001000 00002000 00000000 0000F000
00000000 00000005 00000100
12345678 89ABCDEF 00000000 7FFFFFFF 80000000
12345678 89ABCDEF 00000000 7FFFFFFF 80000000

// File: all.f
+incdir+rtl
rtl/notchPkg.sv
rtl/syncFifo.sv
rtl/notchRegs.sv
rtl/sampleFetch.sv
rtl/biquadCore.sv
rtl/resultStore.sv
rtl/memArbiter.sv
rtl/notchTop.sv
verif/notchTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= notchTb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= sim passed
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
